// ==== branch_target_buffer.sv ====
`timescale 1ns/1ps
`include "fetch_consts.svh"

module branch_target_buffer
    import fetch_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic [`WORD_W-1:0] lookup_pc_i,
    input  branch_fix_t        branch_fix_i,
    output btb_pred_t          pred_o
);

    localparam int ENTRIES = 1 << `BTB_INDEX_BITS;
    localparam int TAG_LO  = `BTB_INDEX_BITS + 2;

    logic [ENTRIES-1:0]       valid_q;
    logic [`BTB_TAG_BITS-1:0] tag_q    [ENTRIES];
    logic [`WORD_W-1:0]       target_q [ENTRIES];

    logic [`BTB_INDEX_BITS-1:0] slot_idx [`FETCH_WIDTH];
    logic [`FETCH_WIDTH-1:0]    slot_hit;
    logic [`FETCH_WIDTH-1:0]    first_hit;
    logic [`WORD_W-1:0]         hit_dest;
    logic [`BTB_INDEX_BITS-1:0] fix_idx;

    //////////////////////////////////////////////////
    // Lookup with one read port per slot
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            slot_idx[i]      = lookup_pc_i[TAG_LO-1:2];
            slot_idx[i][1:0] = 2'(i);               // Word within the group
            slot_hit[i]      = valid_q[slot_idx[i]]
                            && (tag_q[slot_idx[i]] == lookup_pc_i[`WORD_W-1:TAG_LO])
                            && (i >= lookup_pc_i[3:2]);
        end
    end

    // Keep only the first taken slot at or after the PC
    always_comb begin
        logic found;
        found     = 1'b0;
        first_hit = '0;
        hit_dest  = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (slot_hit[i] && !found) begin
                first_hit[i] = 1'b1;
                hit_dest     = target_q[slot_idx[i]];
                found        = 1'b1;
            end
        end
    end

    assign pred_o = '{take: |first_hit, mask: first_hit, dest: hit_dest};

    //////////////////////////////////////////////////
    // Update from branch resolution
    //////////////////////////////////////////////////

    assign fix_idx = branch_fix_i.err_pc[TAG_LO-1:2];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (branch_fix_i.flush) begin
            valid_q[fix_idx] <= branch_fix_i.corr_take;    // Not-taken drops the entry
        end
    end

    always_ff @(posedge clk) begin
        if (branch_fix_i.flush && branch_fix_i.corr_take) begin
            tag_q[fix_idx]    <= branch_fix_i.err_pc[`WORD_W-1:TAG_LO];
            target_q[fix_idx] <= branch_fix_i.corr_dest;
        end
    end

endmodule

// ==== build.f ====
+incdir+.
fetch_pkg.sv
pc_register.sv
branch_target_buffer.sv
first_cache_trace.sv
second_cache_trace.sv
fetch_stage.sv
tb_fetch_stage.sv

// ==== fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

//////////////////////////////////////////////////
// Fetch group geometry
//////////////////////////////////////////////////

`define FETCH_WIDTH     4                   // Instructions per group
`define WORD_W          32
`define GROUP_BYTES     16

// Boot ROM in kseg1
`define RESET_VECTOR    32'hBFC0_0000

//////////////////////////////////////////////////
// Branch target buffer
//////////////////////////////////////////////////

`define BTB_INDEX_BITS  4                   // 16 entries

// Tag is everything above the index and the byte offset
`define BTB_TAG_BITS    (`WORD_W - `BTB_INDEX_BITS - 2)

//////////////////////////////////////////////////
// Exception codes
//////////////////////////////////////////////////

`define EXC_CODE_W      5
`define EXC_ADEL        5'h04               // Address error on load/fetch

`endif

// ==== fetch_pkg.sv ====
`include "fetch_consts.svh"

package fetch_pkg;

    // Branch resolution result
    typedef struct packed {
        logic               flush;
        logic [`WORD_W-1:0] err_pc;
        logic               corr_take;
        logic [`WORD_W-1:0] corr_dest;
    } branch_fix_t;

    typedef struct packed {
        logic               occur;
        logic [`WORD_W-1:0] dest_pc;
    } exc_redirect_t;

    // Only the first taken slot survives in mask
    typedef struct packed {
        logic                    take;
        logic [`FETCH_WIDTH-1:0] mask;
        logic [`WORD_W-1:0]      dest;
    } btb_pred_t;

    typedef struct packed {
        logic [`WORD_W-1:0]      pc;
        logic [`FETCH_WIDTH-1:0] enable;
        btb_pred_t               pred;
        logic                    addr_err;
    } fetch_group_t;

    // Toward the instruction queue
    typedef struct packed {
        logic                                 valid;
        logic [`WORD_W-1:0]                   base_pc;
        logic [`FETCH_WIDTH-1:0]              enable;
        logic [`FETCH_WIDTH-1:0][`WORD_W-1:0] inst;
        btb_pred_t                            pred;
        logic                                 has_exc;
        logic [`EXC_CODE_W-1:0]               exc_code;
    } fetch_bundle_t;

    typedef struct packed {
        logic [`WORD_W-1:0] paddr;          // 16-byte aligned
    } icache_req_t;

endpackage

// ==== fetch_stage.sv ====
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_stage
    import fetch_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    // Instruction cache
    output logic                                 inst_req_o,
    output icache_req_t                          inst_addr_o,
    input  logic                                 inst_index_ok_i,
    input  logic                                 inst_data_ok_i,
    input  logic [`FETCH_WIDTH-1:0][`WORD_W-1:0] inst_rdata_i,
    // Instruction queue
    input  logic                                 stop_fetch_i,
    output fetch_bundle_t                        bundle_o,
    // Redirects
    input  branch_fix_t                          branch_fix_i,
    input  exc_redirect_t                        exc_i
);

    logic               redirect;
    logic [`WORD_W-1:0] redirect_pc;
    logic [`WORD_W-1:0] lookup_pc;
    btb_pred_t          btb_pred;
    fetch_group_t       fetch_group;
    logic               group_take;
    logic               issue_ok;
    fetch_bundle_t      first_bundle;
    logic               first_ready;
    logic               sct_allowin;

    // Exception wins over a branch fix
    assign redirect    = exc_i.occur || branch_fix_i.flush;
    assign redirect_pc = exc_i.occur ? exc_i.dest_pc : branch_fix_i.corr_dest;

    pc_register u_pc_register (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .redirect_i      (redirect),
        .redirect_pc_i   (redirect_pc),
        .pred_i          (btb_pred),
        .issue_ok_i      (issue_ok),
        .inst_index_ok_i (inst_index_ok_i),
        .inst_req_o      (inst_req_o),
        .inst_addr_o     (inst_addr_o),
        .lookup_pc_o     (lookup_pc),
        .group_o         (fetch_group),
        .group_take_o    (group_take)
    );

    branch_target_buffer u_branch_target_buffer (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .lookup_pc_i  (lookup_pc),
        .branch_fix_i (branch_fix_i),
        .pred_o       (btb_pred)
    );

    first_cache_trace u_first_cache_trace (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .group_i        (fetch_group),
        .group_take_i   (group_take),
        .redirect_i     (redirect),
        .inst_data_ok_i (inst_data_ok_i),
        .inst_rdata_i   (inst_rdata_i),
        .sct_allowin_i  (sct_allowin),
        .issue_ok_o     (issue_ok),
        .bundle_o       (first_bundle),
        .bundle_valid_o (first_ready)
    );

    second_cache_trace u_second_cache_trace (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .bundle_i       (first_bundle),
        .bundle_valid_i (first_ready),
        .redirect_i     (redirect),
        .stop_fetch_i   (stop_fetch_i),
        .allowin_o      (sct_allowin),
        .bundle_o       (bundle_o)
    );

endmodule

// ==== first_cache_trace.sv ====
`timescale 1ns/1ps
`include "fetch_consts.svh"

module first_cache_trace
    import fetch_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 arst_n_i,
    input  fetch_group_t                         group_i,
    input  logic                                 group_take_i,
    input  logic                                 redirect_i,
    input  logic                                 inst_data_ok_i,
    input  logic [`FETCH_WIDTH-1:0][`WORD_W-1:0] inst_rdata_i,
    input  logic                                 sct_allowin_i,
    output logic                                 issue_ok_o,
    output fetch_bundle_t                        bundle_o,
    output logic                                 bundle_valid_o
);

    logic                                 busy_q;
    logic                                 cancel_q;   // Data still owed but unwanted
    logic                                 filled_q;   // Data caught while second trace was full
    fetch_group_t                         group_q;
    logic [`FETCH_WIDTH-1:0][`WORD_W-1:0] inst_q;
    logic                                 wait_data;

    assign wait_data      = busy_q && !filled_q && !group_q.addr_err;
    assign bundle_valid_o = busy_q && !cancel_q
                         && (filled_q || group_q.addr_err || inst_data_ok_i);
    assign issue_ok_o     = !busy_q;

    always_comb begin
        bundle_o.valid    = bundle_valid_o;
        bundle_o.base_pc  = group_q.pc;
        bundle_o.enable   = group_q.enable;
        bundle_o.pred     = group_q.pred;
        bundle_o.has_exc  = group_q.addr_err;
        bundle_o.exc_code = group_q.addr_err ? `EXC_ADEL : '0;
        if (group_q.addr_err) begin
            bundle_o.inst = '0;
        end else begin
            bundle_o.inst = filled_q ? inst_q : inst_rdata_i;   // Bypass on data_ok
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q   <= 1'b0;
            cancel_q <= 1'b0;
            filled_q <= 1'b0;
        end else if (redirect_i) begin
            busy_q   <= wait_data && !inst_data_ok_i;
            cancel_q <= wait_data && !inst_data_ok_i;
            filled_q <= 1'b0;
        end else if (busy_q) begin
            if (cancel_q) begin
                if (inst_data_ok_i) begin                  // Swallow it
                    busy_q   <= 1'b0;
                    cancel_q <= 1'b0;
                end
            end else if (bundle_valid_o && sct_allowin_i) begin
                busy_q   <= 1'b0;
                filled_q <= 1'b0;
            end else if (wait_data && inst_data_ok_i) begin
                filled_q <= 1'b1;
            end
        end else if (group_take_i) begin
            busy_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (group_take_i) begin
            group_q <= group_i;
        end
        if (wait_data && inst_data_ok_i) begin
            inst_q <= inst_rdata_i;
        end
    end

    // Cache returns data only for requests the PC register issued
    assert property (@(posedge clk) disable iff (!arst_n_i) inst_data_ok_i |-> wait_data);

endmodule

// ==== pc_register.sv ====
`timescale 1ns/1ps
`include "fetch_consts.svh"

module pc_register
    import fetch_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               redirect_i,
    input  logic [`WORD_W-1:0] redirect_pc_i,
    input  btb_pred_t          pred_i,
    input  logic               issue_ok_i,      // First trace is free
    input  logic               inst_index_ok_i,
    output logic               inst_req_o,
    output icache_req_t        inst_addr_o,
    output logic [`WORD_W-1:0] lookup_pc_o,
    output fetch_group_t       group_o,
    output logic               group_take_o
);

    localparam int OFF_W = $clog2(`GROUP_BYTES);

    logic [`WORD_W-1:0]      fetch_pc_q;
    logic                    run_q;         // Low in the first cycle out of reset
    logic                    halt_q;        // Parked after a misaligned group
    logic                    misaligned;
    logic                    can_issue;
    logic [`WORD_W-1:0]      group_base;
    logic [`FETCH_WIDTH-1:0] enable;
    btb_pred_t               pred;

    assign misaligned = |fetch_pc_q[1:0];
    assign group_base = {fetch_pc_q[`WORD_W-1:OFF_W], {OFF_W{1'b0}}};
    assign can_issue  = run_q && !halt_q && issue_ok_i && !redirect_i;

    assign inst_req_o        = can_issue && !misaligned;
    assign inst_addr_o.paddr = group_base;
    assign group_take_o      = can_issue && (misaligned || inst_index_ok_i);
    assign lookup_pc_o       = fetch_pc_q;

    // From the PC's word through the first predicted-taken slot
    always_comb begin
        logic seen;
        seen = 1'b0;
        pred = misaligned ? '0 : pred_i;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            enable[i] = (i >= fetch_pc_q[OFF_W-1:2]) && !seen;
            seen      = seen | pred.mask[i];
        end
    end

    assign group_o = '{pc: fetch_pc_q, enable: enable, pred: pred, addr_err: misaligned};

    //////////////////////////////////////////////////
    // Next PC
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_pc_q <= `RESET_VECTOR;
            run_q      <= 1'b0;
            halt_q     <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (redirect_i) begin
                fetch_pc_q <= redirect_pc_i;
                halt_q     <= 1'b0;
            end else if (group_take_o) begin
                if (misaligned) begin
                    halt_q <= 1'b1;             // Wait for a redirect
                end else if (pred.take) begin
                    fetch_pc_q <= pred.dest;
                end else begin
                    fetch_pc_q <= group_base + `GROUP_BYTES;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n_i)
        inst_req_o |-> inst_addr_o.paddr[OFF_W-1:0] == '0);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_fetch_stage -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_fetch_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== second_cache_trace.sv ====
`timescale 1ns/1ps
`include "fetch_consts.svh"

module second_cache_trace
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n_i,
    input  fetch_bundle_t bundle_i,
    input  logic          bundle_valid_i,
    input  logic          redirect_i,
    input  logic          stop_fetch_i,     // Queue back-pressure
    output logic          allowin_o,
    output fetch_bundle_t bundle_o
);

    logic          valid_q;
    fetch_bundle_t data_q;

    // Room when empty or when the held bundle leaves this cycle
    assign allowin_o = !valid_q || !stop_fetch_i;

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (redirect_i) begin
            valid_q <= 1'b0;
        end else if (allowin_o) begin
            valid_q <= bundle_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (allowin_o && bundle_valid_i) begin
            data_q <= bundle_i;
        end
    end

    always_comb begin
        bundle_o       = data_q;
        bundle_o.valid = valid_q;
    end

    // Stalled bundle is not disturbed by upstream traffic
    assert property (@(posedge clk) disable iff (!arst_n_i)
        bundle_o.valid && stop_fetch_i && !redirect_i |=> $stable(bundle_o));

endmodule

// ==== tb_fetch_stage.sv ====
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_fetch_stage
    import fetch_pkg::*;
();

    localparam logic [`WORD_W-1:0] ERR_PC     = `RESET_VECTOR + 32'h108;
    localparam logic [`WORD_W-1:0] ERR_GROUP  = `RESET_VECTOR + 32'h100;
    localparam logic [`WORD_W-1:0] TAKEN_DEST = `RESET_VECTOR + 32'h0C4;  // Loops back below ERR_PC
    localparam logic [`WORD_W-1:0] FALL_DEST  = `RESET_VECTOR + 32'h0F8;
    localparam logic [`WORD_W-1:0] EXC_DEST   = `RESET_VECTOR + 32'h380;
    localparam logic [`WORD_W-1:0] BAD_PC     = `RESET_VECTOR + 32'h402;
    localparam logic [`WORD_W-1:0] STALL_DEST = `RESET_VECTOR + 32'h600;
    localparam int BTB_ENTRIES = 1 << `BTB_INDEX_BITS;
    localparam int MAX_CYCLES  = 4000;     // 33 bundles at up to ~100 cycles each plus idle waits

    logic                                 clk = 1'b0;
    logic                                 arst_n_i;
    logic                                 inst_req_o;
    icache_req_t                          inst_addr_o;
    logic                                 inst_index_ok_i;
    logic                                 inst_data_ok_i;
    logic [`FETCH_WIDTH-1:0][`WORD_W-1:0] inst_rdata_i;
    logic                                 stop_fetch_i;
    fetch_bundle_t                        bundle_o;
    branch_fix_t                          branch_fix_i;
    exc_redirect_t                        exc_i;

    int            seed     = 32'hffe24a1b;
    int            errors   = 0;
    int            cycle_cnt;
    string         cur_test = "reset";
    logic          stall_en = 1'b0;
    fetch_bundle_t got_q [$];               // Taken by the queue since the last redirect

    logic               pend = 1'b0;        // Cache holds one accepted request
    logic [`WORD_W-1:0] pend_addr;
    int                 pend_wait;

    logic               btb_valid [BTB_ENTRIES];
    logic [`WORD_W-1:0] btb_pc    [BTB_ENTRIES];
    logic [`WORD_W-1:0] btb_dest  [BTB_ENTRIES];
    logic [`WORD_W-1:0] exp_pc;
    logic               exp_halt;
    logic               held_valid;
    fetch_bundle_t      held_b;

    fetch_stage fetch_stage_i (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Cache model
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!arst_n_i) begin
            pend = 1'b0;
        end else begin
            if (inst_data_ok_i) pend = 1'b0;
            if (inst_req_o && inst_index_ok_i) begin
                if (pend) begin
                    errors++;
                    $display("[%s] cache took a request while one was outstanding", cur_test);
                end
                pend      = 1'b1;
                pend_addr = inst_addr_o.paddr;
                pend_wait = $random(seed) & 3;
            end
        end
    end

    always @(negedge clk) begin
        inst_data_ok_i = 1'b0;
        if (!arst_n_i) begin
            inst_index_ok_i = 1'b0;
            stop_fetch_i    = 1'b0;
        end else begin
            inst_index_ok_i = ($random(seed) & 3) != 0;
            stop_fetch_i    = stall_en && (($random(seed) & 1) != 0);
            if (pend && pend_wait > 0) begin
                pend_wait--;
            end else if (pend) begin
                inst_data_ok_i = 1'b1;
                for (int i = 0; i < `FETCH_WIDTH; i++) begin
                    inst_rdata_i[i] = (pend_addr + 32'(4 * i)) ^ 32'h5A5A_0000;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Reference stream and compare tasks
    //////////////////////////////////////////////////

    function automatic fetch_bundle_t model_bundle(input logic [`WORD_W-1:0] pc);
        fetch_bundle_t              b;
        logic [`WORD_W-1:0]         word_pc;
        logic [`BTB_INDEX_BITS-1:0] idx;
        logic                       seen;
        b         = '0;
        seen      = 1'b0;
        b.valid   = 1'b1;
        b.base_pc = pc;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            word_pc     = {pc[`WORD_W-1:4], 4'b0} + 32'(4 * i);
            idx         = word_pc[`BTB_INDEX_BITS+1:2];
            b.enable[i] = (i >= pc[3:2]) && !seen;
            if (pc[1:0] == 2'b00) begin
                b.inst[i] = word_pc ^ 32'h5A5A_0000;
                if (b.enable[i] && btb_valid[idx] && btb_pc[idx] == word_pc) begin
                    seen         = 1'b1;      // Later slots fall off
                    b.pred.take  = 1'b1;
                    b.pred.mask[i] = 1'b1;
                    b.pred.dest  = btb_dest[idx];
                end
            end
        end
        b.has_exc  = pc[1:0] != 2'b00;
        b.exc_code = b.has_exc ? `EXC_ADEL : '0;
        return b;
    endfunction

    task automatic check_bundle(input string name, input fetch_bundle_t exp,
                                input fetch_bundle_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR [%s] expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [`WORD_W-1:0] exp,
                              input logic [`WORD_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR [%s] expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input logic [`FETCH_WIDTH-1:0] exp,
                              input logic [`FETCH_WIDTH-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERROR [%s] expected %b, actual %b", name, exp, act);
        end
    endtask

    // Queue side checks every taken bundle against the stream
    always @(posedge clk) begin
        fetch_bundle_t exp_b;
        if (!arst_n_i) begin
            exp_pc     = `RESET_VECTOR;
            exp_halt   = 1'b0;
            held_valid = 1'b0;
            for (int i = 0; i < BTB_ENTRIES; i++) btb_valid[i] = 1'b0;
            if (inst_req_o || bundle_o.valid) begin
                errors++;
                $display("[%s] cache request or bundle raised during reset", cur_test);
            end
        end else if (exc_i.occur || branch_fix_i.flush) begin
            exp_pc     = exc_i.occur ? exc_i.dest_pc : branch_fix_i.corr_dest;
            exp_halt   = 1'b0;
            held_valid = 1'b0;
            if (branch_fix_i.flush) begin
                btb_valid[branch_fix_i.err_pc[`BTB_INDEX_BITS+1:2]] = branch_fix_i.corr_take;
                btb_pc[branch_fix_i.err_pc[`BTB_INDEX_BITS+1:2]]    = branch_fix_i.err_pc;
                btb_dest[branch_fix_i.err_pc[`BTB_INDEX_BITS+1:2]]  = branch_fix_i.corr_dest;
            end
        end else begin
            if (held_valid) check_bundle({cur_test, " stall"}, held_b, bundle_o);
            held_valid = bundle_o.valid && stop_fetch_i;
            held_b     = bundle_o;
            if (bundle_o.valid && !stop_fetch_i) begin
                if (exp_halt) begin
                    errors++;
                    $display("[%s] bundle at %h came after an address error", cur_test,
                             bundle_o.base_pc);
                end else begin
                    exp_b = model_bundle(exp_pc);
                    check_bundle(cur_test, exp_b, bundle_o);
                    exp_halt = exp_b.has_exc;
                    exp_pc   = exp_b.pred.take ? exp_b.pred.dest
                                               : {exp_pc[`WORD_W-1:4], 4'b0} + `GROUP_BYTES;
                end
                got_q.push_back(bundle_o);
            end
        end
    end

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic wait_bundles(input int n);
        while (got_q.size() < n) @(negedge clk);
    endtask

    task automatic apply_redirect(input exc_redirect_t exc, input branch_fix_t fix);
        @(negedge clk);
        exc_i        = exc;
        branch_fix_i = fix;
        got_q.delete();
        @(negedge clk);
        exc_i        = '0;
        branch_fix_i = '0;
    endtask

    task automatic sequential_fetch();
        cur_test = "sequential";
        wait_bundles(6);
        for (int i = 0; i < 6; i++) begin
            check_word(cur_test, `RESET_VECTOR + 32'(16 * i), got_q[i].base_pc);
            check_mask(cur_test, 4'hf, got_q[i].enable);
        end
    endtask

    task automatic taken_fix_trains_btb();
        cur_test = "branch_fix";
        apply_redirect('0, '{flush: 1'b1, err_pc: ERR_PC, corr_take: 1'b1, corr_dest: TAKEN_DEST});
        wait_bundles(6);                   // C4, D0, E0, F0, 100, C4
        check_word(cur_test, TAKEN_DEST, got_q[0].base_pc);
        check_mask(cur_test, 4'b1110, got_q[0].enable);
        check_word(cur_test, ERR_GROUP, got_q[4].base_pc);
        check_mask(cur_test, 4'b0100, got_q[4].pred.mask);
        check_word(cur_test, TAKEN_DEST, got_q[4].pred.dest);
        check_mask(cur_test, 4'b0111, got_q[4].enable);
        check_word(cur_test, TAKEN_DEST, got_q[5].base_pc);
    endtask

    task automatic not_taken_clears_btb();
        cur_test = "not_taken";
        apply_redirect('0, '{flush: 1'b1, err_pc: ERR_PC, corr_take: 1'b0, corr_dest: FALL_DEST});
        wait_bundles(4);
        check_mask(cur_test, 4'b1100, got_q[0].enable);
        check_word(cur_test, ERR_GROUP, got_q[1].base_pc);
        check_mask(cur_test, 4'h0, got_q[1].pred.mask);
        check_word(cur_test, ERR_GROUP + 32'h20, got_q[3].base_pc);
    endtask

    task automatic exception_redirect();
        cur_test = "exception";
        apply_redirect('{occur: 1'b1, dest_pc: EXC_DEST},
                       '{flush: 1'b1, err_pc: ERR_PC, corr_take: 1'b1, corr_dest: TAKEN_DEST});
        wait_bundles(4);
        check_word(cur_test, EXC_DEST, got_q[0].base_pc);
        check_word(cur_test, EXC_DEST + 32'h30, got_q[3].base_pc);
        cur_test = "misaligned";
        apply_redirect('{occur: 1'b1, dest_pc: BAD_PC}, '0);
        wait_bundles(1);
        check_word(cur_test, BAD_PC, got_q[0].base_pc);
        check_word(cur_test, 32'd1, 32'(got_q[0].has_exc));
        check_word(cur_test, 32'(`EXC_ADEL), 32'(got_q[0].exc_code));
        repeat (30) @(negedge clk);
        if (got_q.size() != 1) begin
            errors++;
            $display("[%s] fetch went on past the address error", cur_test);
        end
    endtask

    task automatic queue_backpressure();
        cur_test = "backpressure";
        stall_en = 1'b1;
        apply_redirect('{occur: 1'b1, dest_pc: STALL_DEST}, '0);
        wait_bundles(12);
        stall_en = 1'b0;
        for (int i = 0; i < 12; i++) begin
            check_word(cur_test, STALL_DEST + 32'(16 * i), got_q[i].base_pc);
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run stopped at the cycle limit in test %s", cur_test);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        arst_n_i        = 1'b0;
        inst_index_ok_i = 1'b0;
        inst_data_ok_i  = 1'b0;
        inst_rdata_i    = '0;
        stop_fetch_i    = 1'b0;
        branch_fix_i    = '0;
        exc_i           = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        sequential_fetch();
        taken_fix_trains_btb();
        not_taken_clears_btb();
        exception_redirect();
        queue_backpressure();
        $display("Finished with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
